/* all.f */
verilog/rv_decode_pkg.sv
verilog/instr_decoder.sv
verilog/decode_fifo.sv
verilog/hazard_issue.sv
verilog/decode_stage_top.sv
sim/decode_stage_props.sv
sim/decode_stage_tb.sv

/* Makefile */
# Verilator build and run for the decode stage testbench

VERILATOR ?= verilator
TOP       ?= decode_stage_tb
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and check $(LOG) for the pass message"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "=== PASS ===" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* sim/decode_stage_tb.sv */
// Testbench for decode_stage_top with FIFO depth 2; expected records are hand-encoded per RV32I
`timescale 1ns/10ps

module decode_stage_tb import rv_decode_pkg::*; ();

    localparam int NUM         = 14;
    localparam int TIMEOUT_CYC = NUM * 20 + 10 + 100;

    logic                  clk_i;
    logic                  rstn_i;
    logic [XLEN-1:0]       instr_i;
    logic                  instr_valid_i;
    logic                  instr_ready_o;
    logic                  out_valid_o;
    logic                  out_ready_i;
    logic                  illegal_o;
    logic [ALU_OP_W-1:0]   alu_op_o;
    logic [REG_ADDR_W-1:0] rs1_o;
    logic [REG_ADDR_W-1:0] rs2_o;
    logic [REG_ADDR_W-1:0] rd_o;
    logic                  wb_o;
    logic                  use_rs2_o;
    logic                  use_imm_o;
    logic [XLEN-1:0]       imm_o;
    logic                  mem_en_o;
    logic                  mem_we_o;
    logic [MEM_CTRL_W-1:0] mem_ctrl_o;

    logic [XLEN-1:0] words [NUM];
    decoded_instr_t  exp_tab [NUM];
    string           names [NUM];
    decoded_instr_t  out_q [$];  // Issued records, in order
    int              cyc_q [$];  // Issue cycle of each record
    int              cycle;
    int              checks;
    int              errors;
    logic            rand_ready;
    logic            hold_pend;
    decoded_instr_t  held;

    decode_stage_top #(.FIFO_DEPTH(2)) dut_i (
        .clk_i(clk_i), .rstn_i(rstn_i),
        .instr_i(instr_i), .instr_valid_i(instr_valid_i), .instr_ready_o(instr_ready_o),
        .out_valid_o(out_valid_o), .out_ready_i(out_ready_i),
        .illegal_o(illegal_o), .alu_op_o(alu_op_o), .rs1_o(rs1_o), .rs2_o(rs2_o),
        .rd_o(rd_o), .wb_o(wb_o), .use_rs2_o(use_rs2_o), .use_imm_o(use_imm_o),
        .imm_o(imm_o), .mem_en_o(mem_en_o), .mem_we_o(mem_we_o), .mem_ctrl_o(mem_ctrl_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #10 clk_i = ~clk_i;
    end

    always @(posedge clk_i) cycle <= cycle + 1;

    ////////////////////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////////////////////

    function automatic decoded_instr_t make_rec(input logic ill, input logic [3:0] alu,
            input logic [4:0] rs1, input logic [4:0] rs2, input logic [4:0] rd,
            input logic wb, input logic urs2, input logic uimm, input logic [31:0] imm,
            input logic men, input logic mwe, input logic [2:0] mctl);
        decoded_instr_t r;
        r = '0;
        r.illegal  = ill;
        r.alu_op   = alu;
        r.rs1      = rs1;
        r.rs2      = rs2;
        r.rd       = rd;
        r.wb       = wb;
        r.use_rs2  = urs2;
        r.use_imm  = uimm;
        r.imm      = imm;
        r.mem_en   = men;
        r.mem_we   = mwe;
        r.mem_ctrl = mctl;
        return r;
    endfunction

    function automatic decoded_instr_t port_record();
        return make_rec(illegal_o, alu_op_o, rs1_o, rs2_o, rd_o, wb_o, use_rs2_o,
                        use_imm_o, imm_o, mem_en_o, mem_we_o, mem_ctrl_o);
    endfunction

    task automatic check_record(input string name, input decoded_instr_t exp,
                                input decoded_instr_t act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("FAIL %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic check_gap(input string name, input int exp, input int act);
        checks++;
        if (exp != act) begin
            errors++;
            $display("FAIL %s expected gap %0d actual gap %0d", name, exp, act);
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        checks++;
        if (exp != act) begin
            errors++;
            $display("FAIL %s expected %0d actual %0d", name, exp, act);
        end
    endtask

    task automatic load_table();
        // Word, expected record: illegal alu rs1 rs2 rd wb urs2 uimm imm men mwe mctl
        words[0]  = 32'h002081B3; names[0]  = "add x3,x1,x2";
        exp_tab[0]  = make_rec(0, 4'h0, 1, 2, 3, 1, 1, 0, 32'h0, 0, 0, 0);
        words[1]  = 32'h407302B3; names[1]  = "sub x5,x6,x7";
        exp_tab[1]  = make_rec(0, 4'h8, 6, 7, 5, 1, 1, 0, 32'h0, 0, 0, 0);
        words[2]  = 32'hFFF40213; names[2]  = "addi x4,x8,-1";
        exp_tab[2]  = make_rec(0, 4'h0, 8, 0, 4, 1, 0, 1, 32'hFFFFFFFF, 0, 0, 0);
        words[3]  = 32'h40755493; names[3]  = "srai x9,x10,7";
        exp_tab[3]  = make_rec(0, 4'hD, 10, 0, 9, 1, 0, 1, 32'h7, 0, 0, 0);
        words[4]  = 32'h00862583; names[4]  = "lw x11,8(x12)";
        exp_tab[4]  = make_rec(0, 4'h0, 12, 0, 0, 0, 0, 1, 32'h8, 1, 0, 2);
        words[5]  = 32'hFED72E23; names[5]  = "sw x13,-4(x14)";
        exp_tab[5]  = make_rec(0, 4'h0, 14, 13, 0, 0, 1, 1, 32'hFFFFFFFC, 1, 1, 2);
        words[6]  = 32'h00208863; names[6]  = "beq x1,x2,16";
        exp_tab[6]  = make_rec(0, 4'h8, 1, 2, 0, 0, 1, 1, 32'h10, 0, 0, 0);
        words[7]  = 32'h123457B7; names[7]  = "lui x15";
        exp_tab[7]  = make_rec(0, 4'h0, 0, 0, 15, 1, 0, 1, 32'h12345000, 0, 0, 0);
        words[8]  = 32'hFFFFF817; names[8]  = "auipc x16";
        exp_tab[8]  = make_rec(0, 4'h0, 0, 0, 16, 1, 0, 1, 32'hFFFFF000, 0, 0, 0);
        words[9]  = 32'h008000EF; names[9]  = "jal x1,8";
        exp_tab[9]  = make_rec(0, 4'h0, 0, 0, 1, 1, 0, 1, 32'h8, 0, 0, 0);
        words[10] = 32'h004082E7; names[10] = "jalr x5,4(x1)";
        exp_tab[10] = make_rec(0, 4'h0, 1, 0, 5, 1, 0, 1, 32'h4, 0, 0, 0);
        words[11] = 32'h0000000F; names[11] = "fence";
        exp_tab[11] = make_rec(1, 4'h0, 0, 0, 0, 0, 0, 0, 32'h0, 0, 0, 0);
        words[12] = 32'h00000073; names[12] = "ecall";
        exp_tab[12] = make_rec(1, 4'h0, 0, 0, 0, 0, 0, 0, 32'h0, 0, 0, 0);
        words[13] = 32'hDEADBEFF; names[13] = "unknown opcode";
        exp_tab[13] = make_rec(1, 4'h0, 0, 0, 0, 0, 0, 0, 32'h0, 0, 0, 0);
    endtask

    // Call at 2 ns after an edge, returns 2 ns after the transfer edge
    task automatic send(input logic [XLEN-1:0] w);
        instr_i       = w;
        instr_valid_i = 1'b1;
        do @(negedge clk_i); while (!instr_ready_o);
        @(posedge clk_i);
        #2;
        instr_valid_i = 1'b0;
    endtask

    task automatic wait_issues(input int n);
        while (out_q.size() < n) @(negedge clk_i);
    endtask

    task automatic run_gap(input string name, input logic [XLEN-1:0] w0,
                           input logic [XLEN-1:0] w1, input int exp_gap);
        @(posedge clk_i);
        #2;
        out_q.delete();
        cyc_q.delete();
        send(w0);
        send(w1);
        wait_issues(2);
        check_gap(name, exp_gap, cyc_q[1] - cyc_q[0]);
        $display("test %s done, errors %0d", name, errors);
    endtask

    task automatic run_table(input string name);
        @(posedge clk_i);
        #2;
        out_q.delete();
        cyc_q.delete();
        for (int i = 0; i < NUM; i++) begin
            send(words[i]);
        end
        wait_issues(NUM);
        repeat (10) @(negedge clk_i);  // Catch any duplicate issue
        check_count({name, " issue count"}, NUM, out_q.size());
        for (int i = 0; i < NUM && i < out_q.size(); i++) begin
            check_record(names[i], exp_tab[i], out_q[i]);
        end
        $display("test %s done, errors %0d", name, errors);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Output monitor and ready driver
    ////////////////////////////////////////////////////////////////////////////

    always @(negedge clk_i) begin
        if (rstn_i) begin
            if (hold_pend) begin
                if (out_valid_o !== 1'b1) begin
                    errors++;
                    $display("out_valid_o dropped while out_ready_i was low");
                end
                check_record("stall hold", held, port_record());
            end
            hold_pend = out_valid_o && !out_ready_i;
            held      = port_record();
            if (out_valid_o && out_ready_i) begin
                out_q.push_back(port_record());
                cyc_q.push_back(cycle);
            end
        end
    end

    initial begin
        logic [31:0] rnd;
        rnd = $urandom(33237);  // Fixed seed for the back-pressure pattern
        forever begin
            @(posedge clk_i);
            rnd = $urandom;
            #2;
            out_ready_i <= rand_ready ? rnd[0] : 1'b1;
        end
    end

    initial begin
        #(TIMEOUT_CYC * 20);
        $display("watchdog timeout, DUT stopped issuing");
        $display("=== FAIL ===");
        $finish;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        cycle         = 0;
        checks        = 0;
        errors        = 0;
        hold_pend     = 1'b0;
        held          = '0;
        rand_ready    = 1'b0;
        rstn_i        = 1'b0;
        instr_i       = '0;
        instr_valid_i = 1'b0;
        out_ready_i   = 1'b1;
        load_table();
        repeat (10) @(posedge clk_i);
        #2;
        rstn_i = 1'b1;

        @(negedge clk_i);
        check_count("reset out_valid_o", 0, int'(out_valid_o));
        check_count("reset instr_ready_o", 1, int'(instr_ready_o));
        $display("test reset done, errors %0d", errors);

        run_table("table ready high");
        rand_ready = 1'b1;
        run_table("table random ready");
        rand_ready = 1'b0;

        run_gap("dependent pair", 32'hFFF40213, 32'h002201B3, 2);
        run_gap("independent pair", 32'hFFF40213, 32'h002081B3, 1);
        run_gap("x0 dependency", 32'h00140013, 32'h000001B3, 1);
        run_gap("store dependency", 32'hFED72E23, 32'h000E01B3, 1);
        run_gap("branch dependency", 32'h00208863, 32'h000801B3, 1);

        // Chain x4 -> x3 -> x5
        @(posedge clk_i);
        #2;
        out_q.delete();
        cyc_q.delete();
        send(32'hFFF40213);
        send(32'h002201B3);
        send(32'h000182B3);
        wait_issues(3);
        check_gap("chain first", 2, cyc_q[1] - cyc_q[0]);
        check_gap("chain second", 2, cyc_q[2] - cyc_q[1]);
        $display("test chain done, errors %0d", errors);

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

/* sim/decode_stage_props.sv */
// Checks on the issue handshake; bound into every hazard_issue instance, silent unless an assertion fails
`timescale 1ns/10ps

module hazard_issue_props import rv_decode_pkg::*; (
    input logic           clk_i,
    input logic           rstn_i,
    input logic           in_valid_i,
    input logic           out_valid_o,
    input logic           out_ready_i,
    input decoded_instr_t out_data_o
);

    logic bubble;

    assign bubble = in_valid_i && !out_valid_o;  // Head present but held back

    // Stalled output keeps valid and payload
    a_hold_stable: assert property (@(posedge clk_i) disable iff (!rstn_i)
        (out_valid_o && !out_ready_i) |=> (out_valid_o && $stable(out_data_o)))
        else $error("issue output changed while stalled");

    a_single_bubble: assert property (@(posedge clk_i) disable iff (!rstn_i)
        bubble |=> !bubble)
        else $error("two bubble cycles in a row");

    a_rd_zero: assert property (@(posedge clk_i) disable iff (!rstn_i)
        (out_valid_o && !out_data_o.wb) |-> (out_data_o.rd == '0))
        else $error("rd nonzero without writeback");

endmodule

bind hazard_issue hazard_issue_props props_i (
    .clk_i       (clk_i),
    .rstn_i      (rstn_i),
    .in_valid_i  (in_valid_i),
    .out_valid_o (out_valid_o),
    .out_ready_i (out_ready_i),
    .out_data_o  (out_data_o)
);

/* verilog/decode_stage_top.sv */
// Decode stage top; 2-cycle latency accept to out_valid_o, 3 with a hazard bubble, debug word not exported
`timescale 1ns/10ps

module decode_stage_top import rv_decode_pkg::*; #(
    parameter int FIFO_DEPTH = 2
) (
    input  logic                  clk_i,
    input  logic                  rstn_i,
    // Instruction in
    input  logic [XLEN-1:0]       instr_i,
    input  logic                  instr_valid_i,
    output logic                  instr_ready_o,
    // Decoded record out
    output logic                  out_valid_o,
    input  logic                  out_ready_i,
    output logic                  illegal_o,
    output logic [ALU_OP_W-1:0]   alu_op_o,
    output logic [REG_ADDR_W-1:0] rs1_o,
    output logic [REG_ADDR_W-1:0] rs2_o,
    output logic [REG_ADDR_W-1:0] rd_o,
    output logic                  wb_o,
    output logic                  use_rs2_o,
    output logic                  use_imm_o,
    output logic [XLEN-1:0]       imm_o,
    output logic                  mem_en_o,
    output logic                  mem_we_o,
    output logic [MEM_CTRL_W-1:0] mem_ctrl_o
);

    logic           dec_valid;
    logic           dec_ready;
    decoded_instr_t dec_data;
    logic           fifo_valid;
    logic           fifo_ready;
    decoded_instr_t fifo_data;
    decoded_instr_t issue_data;

    instr_decoder u_decoder (
        .clk_i         (clk_i),
        .rstn_i        (rstn_i),
        .instr_i       (instr_i),
        .instr_valid_i (instr_valid_i),
        .instr_ready_o (instr_ready_o),
        .dec_valid_o   (dec_valid),
        .dec_ready_i   (dec_ready),
        .dec_data_o    (dec_data)
    );

    decode_fifo #(
        .DEPTH (FIFO_DEPTH)
    ) u_fifo (
        .clk_i       (clk_i),
        .rstn_i      (rstn_i),
        .in_valid_i  (dec_valid),
        .in_ready_o  (dec_ready),
        .in_data_i   (dec_data),
        .out_valid_o (fifo_valid),
        .out_ready_i (fifo_ready),
        .out_data_o  (fifo_data)
    );

    hazard_issue u_issue (
        .clk_i       (clk_i),
        .rstn_i      (rstn_i),
        .in_valid_i  (fifo_valid),
        .in_ready_o  (fifo_ready),
        .in_data_i   (fifo_data),
        .out_valid_o (out_valid_o),
        .out_ready_i (out_ready_i),
        .out_data_o  (issue_data)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Record to flat ports
    ////////////////////////////////////////////////////////////////////////////

    assign illegal_o  = issue_data.illegal;
    assign alu_op_o   = issue_data.alu_op;
    assign rs1_o      = issue_data.rs1;
    assign rs2_o      = issue_data.rs2;
    assign rd_o       = issue_data.rd;
    assign wb_o       = issue_data.wb;
    assign use_rs2_o  = issue_data.use_rs2;
    assign use_imm_o  = issue_data.use_imm;
    assign imm_o      = issue_data.imm;
    assign mem_en_o   = issue_data.mem_en;
    assign mem_we_o   = issue_data.mem_we;
    assign mem_ctrl_o = issue_data.mem_ctrl;  // issue_data.instr stays internal

endmodule

/* verilog/hazard_issue.sv */
// Issue stage; checks read-after-write only against the last issued record, one bubble per hazard
`timescale 1ns/10ps

module hazard_issue import rv_decode_pkg::*; (
    input  logic           clk_i,
    input  logic           rstn_i,
    input  logic           in_valid_i,
    output logic           in_ready_o,
    input  decoded_instr_t in_data_i,
    output logic           out_valid_o,
    input  logic           out_ready_i,
    output decoded_instr_t out_data_o
);

    logic [REG_ADDR_W-1:0] last_rd_q;    // Zero if last issue wrote nothing
    logic                  bubbled_q;    // Head already paid its bubble
    logic                  rs1_hit;
    logic                  rs2_hit;
    logic                  hazard;
    logic                  issue;

    ////////////////////////////////////////////////////////////////////////////
    // Hazard detection
    ////////////////////////////////////////////////////////////////////////////

    // Unused source fields arrive as zero, x0 never matches
    assign rs1_hit = (in_data_i.rs1 != '0) && (in_data_i.rs1 == last_rd_q);
    assign rs2_hit = in_data_i.use_rs2 && (in_data_i.rs2 != '0) &&
                     (in_data_i.rs2 == last_rd_q);

    assign hazard = in_valid_i && !bubbled_q && (rs1_hit || rs2_hit);

    // Head passes straight through unless this is the bubble cycle
    assign out_valid_o = in_valid_i && !hazard;
    assign in_ready_o  = out_ready_i && !hazard;
    assign out_data_o  = in_data_i;

    assign issue = out_valid_o && out_ready_i;

    ////////////////////////////////////////////////////////////////////////////
    // Issue history
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            last_rd_q <= '0;
            bubbled_q <= 1'b0;
        end else begin
            if (issue) begin
                last_rd_q <= in_data_i.wb ? in_data_i.rd : '0;
            end
            // Held until the stalled head actually issues
            if (hazard) begin
                bubbled_q <= 1'b1;
            end else if (issue) begin
                bubbled_q <= 1'b0;
            end
        end
    end

endmodule

/* verilog/decode_fifo.sv */
// Decoded-instruction FIFO; DEPTH must be a power of two and at least 2, head is registered storage
`timescale 1ns/10ps

module decode_fifo import rv_decode_pkg::*; #(
    parameter int DEPTH = 2
) (
    input  logic           clk_i,
    input  logic           rstn_i,
    input  logic           in_valid_i,
    output logic           in_ready_o,
    input  decoded_instr_t in_data_i,
    output logic           out_valid_o,
    input  logic           out_ready_i,
    output decoded_instr_t out_data_o
);

    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    decoded_instr_t mem_q [DEPTH];

    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] count_q;
    logic             push;
    logic             pop;

    assign in_ready_o  = (count_q != CNT_W'(DEPTH));
    assign out_valid_o = (count_q != '0);
    assign out_data_o  = mem_q[rd_ptr_q];

    assign push = in_valid_i && in_ready_o;
    assign pop  = out_valid_o && out_ready_i;

    ////////////////////////////////////////////////////////////////////////////
    // Pointers and fill level
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;  // Wraps, DEPTH is 2^n
            end
            if (pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            if (push && !pop) begin
                count_q <= count_q + 1'b1;
            end else if (pop && !push) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

    // Storage
    always_ff @(posedge clk_i) begin
        if (push) begin
            mem_q[wr_ptr_q] <= in_data_i;
        end
    end

endmodule

/* verilog/instr_decoder.sv */
// RV32I decoder with one output register; instr_i must hold steady while valid is high and not ready
`timescale 1ns/10ps

module instr_decoder import rv_decode_pkg::*; (
    input  logic           clk_i,
    input  logic           rstn_i,
    input  logic [XLEN-1:0] instr_i,
    input  logic           instr_valid_i,
    output logic           instr_ready_o,
    output logic           dec_valid_o,
    input  logic           dec_ready_i,
    output decoded_instr_t dec_data_o
);

    ////////////////////////////////////////////////////////////////////////////
    // Instruction fields
    ////////////////////////////////////////////////////////////////////////////

    opcode_e               opcode;
    logic [2:0]            funct3;
    logic [6:0]            funct7;
    logic [REG_ADDR_W-1:0] rs1_f;
    logic [REG_ADDR_W-1:0] rs2_f;
    logic [REG_ADDR_W-1:0] rd_f;
    logic                  alt_bit;   // Bit 30, SUB/SRA select
    logic                  is_shift;

    logic [XLEN-1:0] imm_i;
    logic [XLEN-1:0] imm_s;
    logic [XLEN-1:0] imm_b;
    logic [XLEN-1:0] imm_u;
    logic [XLEN-1:0] imm_j;
    logic [XLEN-1:0] imm_sh;

    decoded_instr_t dec_d;
    logic           accept;

    assign opcode = opcode_e'(instr_i[6:0]);
    assign rd_f   = instr_i[11:7];
    assign funct3 = instr_i[14:12];
    assign rs1_f  = instr_i[19:15];
    assign rs2_f  = instr_i[24:20];
    assign funct7 = instr_i[31:25];

    assign alt_bit  = |(funct7 & FUNCT7_ALT);
    // Only SLLI (001) and SRxI (101) have funct3[1:0] == 01
    assign is_shift = (funct3[1:0] == 2'b01);

    ////////////////////////////////////////////////////////////////////////////
    // Immediates
    ////////////////////////////////////////////////////////////////////////////

    assign imm_i  = {{20{instr_i[31]}}, instr_i[31:20]};
    assign imm_s  = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
    assign imm_b  = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                     instr_i[11:8], 1'b0};
    assign imm_u  = {instr_i[31:12], 12'b0};
    assign imm_j  = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12], instr_i[20],
                     instr_i[30:21], 1'b0};
    assign imm_sh = {{(XLEN-5){1'b0}}, instr_i[24:20]};  // Zero-extended shamt

    ////////////////////////////////////////////////////////////////////////////
    // Field decode
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        dec_d          = '0;
        dec_d.alu_op   = ALU_ADD;
        dec_d.instr    = instr_i;
        case (opcode)
            OPC_LOAD: begin
                dec_d.rs1      = rs1_f;
                dec_d.wb       = 1'b0;  // Load writeback belongs to the LSU path
                dec_d.use_imm  = 1'b1;
                dec_d.imm      = imm_i;
                dec_d.mem_en   = 1'b1;
                dec_d.mem_ctrl = funct3;
            end
            OPC_STORE: begin
                dec_d.rs1      = rs1_f;
                dec_d.rs2      = rs2_f;
                dec_d.use_rs2  = 1'b1;  // Store data
                dec_d.use_imm  = 1'b1;
                dec_d.imm      = imm_s;
                dec_d.mem_en   = 1'b1;
                dec_d.mem_we   = 1'b1;
                dec_d.mem_ctrl = funct3;
            end
            OPC_OP: begin
                dec_d.alu_op  = {alt_bit, funct3};
                dec_d.rs1     = rs1_f;
                dec_d.rs2     = rs2_f;
                dec_d.wb      = 1'b1;
                dec_d.use_rs2 = 1'b1;
            end
            OPC_OPIMM: begin
                // Bit 30 is part of the immediate except for right shifts
                dec_d.alu_op  = {(funct3 == FUNCT3_SR) ? alt_bit : 1'b0, funct3};
                dec_d.rs1     = rs1_f;
                dec_d.wb      = 1'b1;
                dec_d.use_imm = 1'b1;
                dec_d.imm     = is_shift ? imm_sh : imm_i;
            end
            OPC_LUI, OPC_AUIPC: begin
                dec_d.wb      = 1'b1;
                dec_d.use_imm = 1'b1;
                dec_d.imm     = imm_u;
            end
            OPC_BRANCH: begin
                dec_d.alu_op  = {1'b1, funct3};  // Compare ops
                dec_d.rs1     = rs1_f;
                dec_d.rs2     = rs2_f;
                dec_d.use_rs2 = 1'b1;
                dec_d.use_imm = 1'b1;  // Branch offset
                dec_d.imm     = imm_b;
            end
            OPC_JAL: begin
                dec_d.wb      = 1'b1;
                dec_d.use_imm = 1'b1;
                dec_d.imm     = imm_j;
            end
            OPC_JALR: begin
                dec_d.rs1     = rs1_f;
                dec_d.wb      = 1'b1;
                dec_d.use_imm = 1'b1;
                dec_d.imm     = imm_i;
            end
            default: begin
                dec_d.illegal = 1'b1;  // Passes through, no writeback, no access
            end
        endcase
        dec_d.rd = dec_d.wb ? rd_f : '0;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Output register
    ////////////////////////////////////////////////////////////////////////////

    // Take a new word when empty or when the current record leaves this cycle
    assign instr_ready_o = !dec_valid_o || dec_ready_i;
    assign accept        = instr_valid_i && instr_ready_o;

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            dec_valid_o <= 1'b0;
        end else if (accept) begin
            dec_valid_o <= 1'b1;
        end else if (dec_ready_i) begin
            dec_valid_o <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            dec_data_o <= dec_d;
        end
    end

endmodule

/* verilog/rv_decode_pkg.sv */
// Shared RV32I decode definitions; MISC-MEM and SYSTEM have no opcode entry and decode as illegal
package rv_decode_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Widths
    ////////////////////////////////////////////////////////////////////////////

    parameter int XLEN       = 32;  // Instruction and data width
    parameter int REG_ADDR_W = 5;   // x0..x31
    parameter int ALU_OP_W   = 4;   // {alt bit, funct3}
    parameter int MEM_CTRL_W = 3;   // Load/store funct3, size and sign

    ////////////////////////////////////////////////////////////////////////////
    // Encodings
    ////////////////////////////////////////////////////////////////////////////

    // Standard RV32I major opcodes, bits [6:0] of the word
    typedef enum logic [6:0] {
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_OP     = 7'b0110011,
        OPC_OPIMM  = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111
    } opcode_e;

    parameter logic [ALU_OP_W-1:0] ALU_ADD    = 4'b0000;     // Also used for address calc
    parameter logic [2:0]          FUNCT3_SR  = 3'b101;      // SRL/SRA, SRLI/SRAI
    parameter logic [6:0]          FUNCT7_ALT = 7'b0100000;  // SUB, SRA, SRAI

    ////////////////////////////////////////////////////////////////////////////
    // Decoded record
    ////////////////////////////////////////////////////////////////////////////

    // Register addresses are zero whenever the field is not used,
    // so the hazard check can compare them without looking at the opcode
    typedef struct packed {
        logic                  illegal;   // Unknown opcode
        logic [ALU_OP_W-1:0]   alu_op;
        logic [REG_ADDR_W-1:0] rs1;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rd;        // Zero when wb is clear
        logic                  wb;        // Writes rd
        logic                  use_rs2;
        logic                  use_imm;
        logic [XLEN-1:0]       imm;       // Sign extended, or shamt
        logic                  mem_en;    // LOAD or STORE
        logic                  mem_we;    // STORE only
        logic [MEM_CTRL_W-1:0] mem_ctrl;  // funct3 of the access
        logic [XLEN-1:0]       instr;     // Raw word for trace
    } decoded_instr_t;

endpackage
